// File: hdl/clock_panel_macros.svh
`ifndef CLOCK_PANEL_MACROS_SVH
`define CLOCK_PANEL_MACROS_SVH

// separator digit between hh, mm and ss
`define SEP_DIGIT 4'd10

// field limits in bcd
`define YEAR_MIN 16'h1970
`define YEAR_MAX 16'h9999
`define MONTH_MAX 8'h12
`define HOUR_MAX 8'h23
`define MINSEC_MAX 8'h59

// decimal point masks
`define DOT_TIME 8'b11111111
`define DOT_DATE 8'b11101010

// blink masks for the selected field
`define BLINK_LOW2 8'b00000011
`define BLINK_MID2 8'b00011000
`define BLINK_MONTH 8'b00001100
`define BLINK_HIGH2 8'b11000000
`define BLINK_HIGH4 8'b11110000

`endif

// File: hdl/clock_panel_pkg.sv
package clock_panel_pkg;

  // panel modes, codes 8 to 15 are unused and hold state
  typedef enum logic [3:0] {
    TIME_DISP        = 4'd0,
    DATE_DISP        = 4'd1,
    TIME_EDIT_SECOND = 4'd2,
    TIME_EDIT_MINUTE = 4'd3,
    TIME_EDIT_HOUR   = 4'd4,
    TIME_EDIT_DAY    = 4'd5,
    TIME_EDIT_MONTH  = 4'd6,
    TIME_EDIT_YEAR   = 4'd7
  } mode_e;

  typedef logic [7:0] bcd2_t;   // two bcd digits
  typedef logic [15:0] bcd4_t;  // four bcd digits, year only

  typedef logic [3:0] digit_t;  // 0-9 digits, 10 is the separator
  typedef logic [7:0] mask_t;   // bit 7 is digit 7, the leftmost

  typedef struct packed {
    bcd4_t year;
    bcd2_t month;
    bcd2_t day;
  } date_fields_s;

  // same 32 bits seen as yyyymmdd digits, element 7 on top
  typedef union packed {
    date_fields_s fields;
    digit_t [7:0] digits;
  } date_word_u;

endpackage

// File: hdl/button_edge.sv
module button_edge (
  input  logic clk,
  input  logic rst_n,
  input  logic up_btn,
  input  logic down_btn,
  output logic step_up,
  output logic step_down
);

  logic [1:0] up_hist;
  logic [1:0] down_hist;

  // history starts high so reset gives no edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      up_hist   <= 2'b11;
      down_hist <= 2'b11;
    end else begin
      up_hist   <= {up_hist[0], up_btn};
      down_hist <= {down_hist[0], down_btn};
    end
  end

  assign step_up   = (up_hist == 2'b10);    // high then low
  assign step_down = (down_hist == 2'b10);

endmodule

// File: hdl/day_limit.sv
module day_limit (
  input  logic                   clk,
  input  logic                   rst_n,
  input  clock_panel_pkg::bcd4_t year,
  input  clock_panel_pkg::bcd2_t month,
  output clock_panel_pkg::bcd2_t day_max
);

  logic [13:0] year_bin;
  logic        leap;

  assign year_bin = 14'(year[15:12]) * 14'd1000
                  + 14'(year[11:8]) * 14'd100
                  + 14'(year[7:4]) * 14'd10
                  + 14'(year[3:0]);

  // gregorian rule
  assign leap = ((year_bin % 14'd4 == 14'd0) && (year_bin % 14'd100 != 14'd0))
              || (year_bin % 14'd400 == 14'd0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      day_max <= 8'h31;
    end else begin
      case (month)
        8'h01, 8'h03, 8'h05, 8'h07, 8'h08, 8'h10, 8'h12: begin
          day_max <= 8'h31;
        end
        8'h04, 8'h06, 8'h09, 8'h11: begin
          day_max <= 8'h30;
        end
        default: begin
          day_max <= leap ? 8'h29 : 8'h28;  // february and bad codes
        end
      endcase
    end
  end

endmodule

// File: hdl/time_editor.sv
`include "clock_panel_macros.svh"

module time_editor (
  input  logic                        clk,
  input  logic                        rst_n,
  input  clock_panel_pkg::mode_e      mode,
  input  logic                        step_up,
  input  logic                        step_down,
  input  clock_panel_pkg::bcd4_t      year_bcd,
  input  clock_panel_pkg::bcd2_t      month_bcd,
  input  clock_panel_pkg::bcd2_t      day_bcd,
  input  clock_panel_pkg::bcd2_t      hour_bcd,
  input  clock_panel_pkg::bcd2_t      minute_bcd,
  input  clock_panel_pkg::bcd2_t      second_bcd,
  output clock_panel_pkg::bcd2_t      edit_hms_hour,
  output clock_panel_pkg::bcd2_t      edit_hms_minute,
  output clock_panel_pkg::bcd2_t      edit_hms_second,
  output clock_panel_pkg::date_word_u edit_date,
  output logic                        set_time,
  output clock_panel_pkg::bcd4_t      new_year,
  output clock_panel_pkg::bcd2_t      new_month,
  output clock_panel_pkg::bcd2_t      new_day,
  output clock_panel_pkg::bcd2_t      new_hour,
  output clock_panel_pkg::bcd2_t      new_minute,
  output clock_panel_pkg::bcd2_t      new_second
);

  clock_panel_pkg::bcd2_t day_max;
  clock_panel_pkg::mode_e prev_mode;
  logic                   step;
  logic                   inc;
  logic                   in_disp;
  logic                   in_edit;
  logic                   commit;

  // bcd step by one with wrap between lo and hi
  function automatic clock_panel_pkg::bcd4_t wrap_step(
    input clock_panel_pkg::bcd4_t v,
    input clock_panel_pkg::bcd4_t lo,
    input clock_panel_pkg::bcd4_t hi,
    input logic                   up
  );
    clock_panel_pkg::bcd4_t r;
    logic                   carry;
    r = v;
    carry = 1'b1;
    for (int i = 0; i < 4; i++) begin
      if (carry) begin
        if (up) begin
          carry = (r[4*i +: 4] == 4'd9);
          r[4*i +: 4] = carry ? 4'd0 : r[4*i +: 4] + 4'd1;
        end else begin
          carry = (r[4*i +: 4] == 4'd0);
          r[4*i +: 4] = carry ? 4'd9 : r[4*i +: 4] - 4'd1;
        end
      end
    end
    if (up) begin
      return (v >= hi) ? lo : r;
    end
    return (v <= lo) ? hi : r;
  endfunction

  function automatic clock_panel_pkg::bcd2_t step2(
    input clock_panel_pkg::bcd2_t v,
    input clock_panel_pkg::bcd2_t lo,
    input clock_panel_pkg::bcd2_t hi,
    input logic                   up
  );
    return 8'(wrap_step({8'h00, v}, {8'h00, lo}, {8'h00, hi}, up));
  endfunction

  assign step    = step_down | step_up;
  assign inc     = step_down;  // down wins on a tie
  assign in_disp = (mode == clock_panel_pkg::TIME_DISP) || (mode == clock_panel_pkg::DATE_DISP);
  assign in_edit = mode inside {[clock_panel_pkg::TIME_EDIT_SECOND :
                                 clock_panel_pkg::TIME_EDIT_YEAR]};
  assign commit  = (prev_mode inside {[clock_panel_pkg::TIME_EDIT_SECOND :
                                       clock_panel_pkg::TIME_EDIT_YEAR]})
                && (mode == clock_panel_pkg::TIME_DISP);

  day_limit i_day_limit (
    .clk    (clk),
    .rst_n  (rst_n),
    .year   (edit_date.fields.year),
    .month  (edit_date.fields.month),
    .day_max(day_max)
  );

  always_ff @(posedge clk) begin
    if (in_disp) begin
      edit_hms_hour          <= hour_bcd;  // track live time
      edit_hms_minute        <= minute_bcd;
      edit_hms_second        <= second_bcd;
      edit_date.fields.year  <= year_bcd;
      edit_date.fields.month <= month_bcd;
      edit_date.fields.day   <= day_bcd;
    end else if (in_edit && step) begin
      case (mode)
        clock_panel_pkg::TIME_EDIT_SECOND:
          edit_hms_second <= step2(edit_hms_second, 8'h00, `MINSEC_MAX, inc);
        clock_panel_pkg::TIME_EDIT_MINUTE:
          edit_hms_minute <= step2(edit_hms_minute, 8'h00, `MINSEC_MAX, inc);
        clock_panel_pkg::TIME_EDIT_HOUR:
          edit_hms_hour <= step2(edit_hms_hour, 8'h00, `HOUR_MAX, inc);
        clock_panel_pkg::TIME_EDIT_DAY:
          edit_date.fields.day <= step2(edit_date.fields.day, 8'h01, day_max, inc);
        clock_panel_pkg::TIME_EDIT_MONTH:
          edit_date.fields.month <= step2(edit_date.fields.month, 8'h01, `MONTH_MAX, inc);
        default:  // year
          edit_date.fields.year <= wrap_step(edit_date.fields.year, `YEAR_MIN, `YEAR_MAX, inc);
      endcase
    end else if (in_edit && (edit_date.fields.day > day_max)) begin
      edit_date.fields.day <= day_max;  // month or year shrank the limit
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_mode <= clock_panel_pkg::TIME_DISP;
      set_time  <= 1'b0;
    end else begin
      prev_mode <= mode;
      set_time  <= commit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      new_year   <= '0;
      new_month  <= '0;
      new_day    <= '0;
      new_hour   <= '0;
      new_minute <= '0;
      new_second <= '0;
    end else if (commit) begin
      new_year   <= edit_date.fields.year;
      new_month  <= edit_date.fields.month;
      new_day    <= edit_date.fields.day;
      new_hour   <= edit_hms_hour;
      new_minute <= edit_hms_minute;
      new_second <= edit_hms_second;
    end
  end

endmodule

// File: hdl/display_driver.sv
`include "clock_panel_macros.svh"

module display_driver (
  input  logic                        clk,
  input  logic                        rst_n,
  input  clock_panel_pkg::mode_e      mode,
  input  clock_panel_pkg::bcd4_t      year_bcd,
  input  clock_panel_pkg::bcd2_t      month_bcd,
  input  clock_panel_pkg::bcd2_t      day_bcd,
  input  clock_panel_pkg::bcd2_t      hour_bcd,
  input  clock_panel_pkg::bcd2_t      minute_bcd,
  input  clock_panel_pkg::bcd2_t      second_bcd,
  input  clock_panel_pkg::bcd2_t      edit_hms_hour,
  input  clock_panel_pkg::bcd2_t      edit_hms_minute,
  input  clock_panel_pkg::bcd2_t      edit_hms_second,
  input  clock_panel_pkg::date_word_u edit_date,
  output clock_panel_pkg::digit_t     led0,
  output clock_panel_pkg::digit_t     led1,
  output clock_panel_pkg::digit_t     led2,
  output clock_panel_pkg::digit_t     led3,
  output clock_panel_pkg::digit_t     led4,
  output clock_panel_pkg::digit_t     led5,
  output clock_panel_pkg::digit_t     led6,
  output clock_panel_pkg::digit_t     led7,
  output clock_panel_pkg::mask_t      dot,
  output clock_panel_pkg::mask_t      blink
);

  clock_panel_pkg::digit_t [7:0] frame_q;

  // hh-mm-ss layout
  function automatic logic [31:0] hms_frame(
    input clock_panel_pkg::bcd2_t h,
    input clock_panel_pkg::bcd2_t m,
    input clock_panel_pkg::bcd2_t s
  );
    return {h, `SEP_DIGIT, m, `SEP_DIGIT, s};
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_q <= '0;
    end else begin
      case (mode)
        clock_panel_pkg::TIME_DISP:
          frame_q <= hms_frame(hour_bcd, minute_bcd, second_bcd);
        clock_panel_pkg::DATE_DISP:
          frame_q <= {year_bcd, month_bcd, day_bcd};
        clock_panel_pkg::TIME_EDIT_SECOND, clock_panel_pkg::TIME_EDIT_MINUTE,
        clock_panel_pkg::TIME_EDIT_HOUR:
          frame_q <= hms_frame(edit_hms_hour, edit_hms_minute, edit_hms_second);
        clock_panel_pkg::TIME_EDIT_DAY, clock_panel_pkg::TIME_EDIT_MONTH,
        clock_panel_pkg::TIME_EDIT_YEAR:
          frame_q <= edit_date.digits;  // yyyymmdd
        default:
          frame_q <= frame_q;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      {led7, led6, led5, led4, led3, led2, led1, led0} <= '0;
    end else begin
      {led7, led6, led5, led4, led3, led2, led1, led0} <= frame_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dot   <= `DOT_TIME;
      blink <= '0;
    end else begin
      case (mode)
        clock_panel_pkg::TIME_DISP:        {dot, blink} <= {`DOT_TIME, 8'h00};
        clock_panel_pkg::DATE_DISP:        {dot, blink} <= {`DOT_DATE, 8'h00};
        clock_panel_pkg::TIME_EDIT_SECOND: {dot, blink} <= {`DOT_TIME, `BLINK_LOW2};
        clock_panel_pkg::TIME_EDIT_MINUTE: {dot, blink} <= {`DOT_TIME, `BLINK_MID2};
        clock_panel_pkg::TIME_EDIT_HOUR:   {dot, blink} <= {`DOT_TIME, `BLINK_HIGH2};
        clock_panel_pkg::TIME_EDIT_DAY:    {dot, blink} <= {`DOT_DATE, `BLINK_LOW2};
        clock_panel_pkg::TIME_EDIT_MONTH:  {dot, blink} <= {`DOT_DATE, `BLINK_MONTH};
        clock_panel_pkg::TIME_EDIT_YEAR:   {dot, blink} <= {`DOT_DATE, `BLINK_HIGH4};
        default:                           {dot, blink} <= {dot, blink};
      endcase
    end
  end

endmodule

// File: hdl/clock_panel.sv
module clock_panel (
  input  logic                    clk,
  input  logic                    rst_n,
  input  clock_panel_pkg::mode_e  mode,
  input  logic                    up_btn,
  input  logic                    down_btn,
  input  clock_panel_pkg::bcd4_t  year_bcd,
  input  clock_panel_pkg::bcd2_t  month_bcd,
  input  clock_panel_pkg::bcd2_t  day_bcd,
  input  clock_panel_pkg::bcd2_t  hour_bcd,
  input  clock_panel_pkg::bcd2_t  minute_bcd,
  input  clock_panel_pkg::bcd2_t  second_bcd,
  output clock_panel_pkg::digit_t led0,
  output clock_panel_pkg::digit_t led1,
  output clock_panel_pkg::digit_t led2,
  output clock_panel_pkg::digit_t led3,
  output clock_panel_pkg::digit_t led4,
  output clock_panel_pkg::digit_t led5,
  output clock_panel_pkg::digit_t led6,
  output clock_panel_pkg::digit_t led7,
  output clock_panel_pkg::mask_t  dot,
  output clock_panel_pkg::mask_t  blink,
  output logic                    set_time,
  output clock_panel_pkg::bcd4_t  new_year,
  output clock_panel_pkg::bcd2_t  new_month,
  output clock_panel_pkg::bcd2_t  new_day,
  output clock_panel_pkg::bcd2_t  new_hour,
  output clock_panel_pkg::bcd2_t  new_minute,
  output clock_panel_pkg::bcd2_t  new_second
);

  logic                        step_up;
  logic                        step_down;
  clock_panel_pkg::bcd2_t      edit_hms_hour;
  clock_panel_pkg::bcd2_t      edit_hms_minute;
  clock_panel_pkg::bcd2_t      edit_hms_second;
  clock_panel_pkg::date_word_u edit_date;

  button_edge i_button_edge (
    .clk      (clk),
    .rst_n    (rst_n),
    .up_btn   (up_btn),
    .down_btn (down_btn),
    .step_up  (step_up),
    .step_down(step_down)
  );

  time_editor i_time_editor (
    .clk            (clk),
    .rst_n          (rst_n),
    .mode           (mode),
    .step_up        (step_up),
    .step_down      (step_down),
    .year_bcd       (year_bcd),
    .month_bcd      (month_bcd),
    .day_bcd        (day_bcd),
    .hour_bcd       (hour_bcd),
    .minute_bcd     (minute_bcd),
    .second_bcd     (second_bcd),
    .edit_hms_hour  (edit_hms_hour),
    .edit_hms_minute(edit_hms_minute),
    .edit_hms_second(edit_hms_second),
    .edit_date      (edit_date),
    .set_time       (set_time),
    .new_year       (new_year),
    .new_month      (new_month),
    .new_day        (new_day),
    .new_hour       (new_hour),
    .new_minute     (new_minute),
    .new_second     (new_second)
  );

  display_driver i_display_driver (
    .clk            (clk),
    .rst_n          (rst_n),
    .mode           (mode),
    .year_bcd       (year_bcd),
    .month_bcd      (month_bcd),
    .day_bcd        (day_bcd),
    .hour_bcd       (hour_bcd),
    .minute_bcd     (minute_bcd),
    .second_bcd     (second_bcd),
    .edit_hms_hour  (edit_hms_hour),
    .edit_hms_minute(edit_hms_minute),
    .edit_hms_second(edit_hms_second),
    .edit_date      (edit_date),
    .led0           (led0),
    .led1           (led1),
    .led2           (led2),
    .led3           (led3),
    .led4           (led4),
    .led5           (led5),
    .led6           (led6),
    .led7           (led7),
    .dot            (dot),
    .blink          (blink)
  );

endmodule

// File: testbench/clock_panel_props.sv
`include "clock_panel_macros.svh"

module clock_panel_props (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   set_time,
  input logic                   step_up,
  input logic                   step_down,
  input clock_panel_pkg::mask_t dot
);

  // commit strobe is a single cycle
  set_time_single: assert property (@(posedge clk) disable iff (!rst_n) set_time |=> !set_time)
    else $error("set_time high on two consecutive cycles");

  step_up_single: assert property (@(posedge clk) disable iff (!rst_n) step_up |=> !step_up)
    else $error("step_up high on two consecutive cycles");

  step_down_single: assert property (@(posedge clk) disable iff (!rst_n)
                                     step_down |=> !step_down)
    else $error("step_down high on two consecutive cycles");

  dot_legal: assert property (@(posedge clk) disable iff (!rst_n)
                              (dot == `DOT_TIME) || (dot == `DOT_DATE))
    else $error("dot mask is neither the time nor the date pattern");

endmodule

bind clock_panel clock_panel_props i_clock_panel_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .set_time (set_time),
  .step_up  (step_up),
  .step_down(step_down),
  .dot      (dot)
);

// File: testbench/clock_panel_tb.sv
module clock_panel_tb;

  logic                          clk;
  logic                          rst_n;
  clock_panel_pkg::mode_e        mode;
  logic                          up_btn;
  logic                          down_btn;
  clock_panel_pkg::bcd4_t        year_bcd;
  clock_panel_pkg::bcd2_t        month_bcd;
  clock_panel_pkg::bcd2_t        day_bcd;
  clock_panel_pkg::bcd2_t        hour_bcd;
  clock_panel_pkg::bcd2_t        minute_bcd;
  clock_panel_pkg::bcd2_t        second_bcd;
  clock_panel_pkg::digit_t       led0;
  clock_panel_pkg::digit_t       led1;
  clock_panel_pkg::digit_t       led2;
  clock_panel_pkg::digit_t       led3;
  clock_panel_pkg::digit_t       led4;
  clock_panel_pkg::digit_t       led5;
  clock_panel_pkg::digit_t       led6;
  clock_panel_pkg::digit_t       led7;
  clock_panel_pkg::mask_t        dot;
  clock_panel_pkg::mask_t        blink;
  logic                          set_time;
  clock_panel_pkg::bcd4_t        new_year;
  clock_panel_pkg::bcd2_t        new_month;
  clock_panel_pkg::bcd2_t        new_day;
  clock_panel_pkg::bcd2_t        new_hour;
  clock_panel_pkg::bcd2_t        new_minute;
  clock_panel_pkg::bcd2_t        new_second;
  clock_panel_pkg::digit_t [7:0] leds;
  logic [47:0]                   panel_out;
  int                            ly;  // live fields as integers
  int                            lmo;
  int                            ld;
  int                            lh;
  int                            lmi;
  int                            ls;

  clock_panel i_clock_panel (.*);

  assign leds      = {led7, led6, led5, led4, led3, led2, led1, led0};
  assign panel_out = {leds, dot, blink};

  always #50 clk = ~clk;

  function automatic clock_panel_pkg::bcd2_t to_bcd2(input int v);
    return {4'(v / 10), 4'(v % 10)};
  endfunction

  function automatic clock_panel_pkg::bcd4_t to_bcd4(input int v);
    return {to_bcd2(v / 100), to_bcd2(v % 100)};
  endfunction

  // reference wrap rule where inc is a down press
  function automatic int next_value(input int v, input int lo, input int hi, input bit inc);
    if (inc) begin
      return (v >= hi) ? lo : v + 1;
    end
    return (v <= lo) ? hi : v - 1;
  endfunction

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
    $display("[ERROR] time %0t: %s expected %h, got %h", $time, name, exp, act);
    stop_with_failure();
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) report_mismatch(name, 16'(exp), 16'(act));
  endtask

  task automatic check_digit(input string name, input clock_panel_pkg::digit_t exp,
                             input clock_panel_pkg::digit_t act);
    if (act !== exp) report_mismatch(name, 16'(exp), 16'(act));
  endtask

  task automatic check_mask(input string name, input clock_panel_pkg::mask_t exp,
                            input clock_panel_pkg::mask_t act);
    if (act !== exp) report_mismatch(name, 16'(exp), 16'(act));
  endtask

  task automatic check_bcd2(input string name, input clock_panel_pkg::bcd2_t exp,
                            input clock_panel_pkg::bcd2_t act);
    if (act !== exp) report_mismatch(name, 16'(exp), 16'(act));
  endtask

  task automatic check_bcd4(input string name, input clock_panel_pkg::bcd4_t exp,
                            input clock_panel_pkg::bcd4_t act);
    if (act !== exp) report_mismatch(name, exp, act);
  endtask

  task automatic check_frame(input clock_panel_pkg::digit_t [7:0] exp);
    for (int i = 0; i < 8; i++) begin
      check_digit($sformatf("led%0d", i), exp[i], leds[i]);
    end
  endtask

  task automatic check_time(input int h, input int m, input int s);
    check_frame({to_bcd2(h), 4'd10, to_bcd2(m), 4'd10, to_bcd2(s)});  // hh-mm-ss
  endtask

  task automatic check_date(input int y, input int mo, input int d);
    check_frame({to_bcd4(y), to_bcd2(mo), to_bcd2(d)});
  endtask

  task automatic set_live(input int y, input int mo, input int d,
                          input int h, input int mi, input int s);
    ly         = y;
    lmo        = mo;
    ld         = d;
    lh         = h;
    lmi        = mi;
    ls         = s;
    year_bcd   = to_bcd4(y);
    month_bcd  = to_bcd2(mo);
    day_bcd    = to_bcd2(d);
    hour_bcd   = to_bcd2(h);
    minute_bcd = to_bcd2(mi);
    second_bcd = to_bcd2(s);
  endtask

  task automatic set_random_live();
    set_live(1970 + int'($urandom_range(99)), 1 + int'($urandom_range(11)),
             1 + int'($urandom_range(27)), int'($urandom_range(23)),
             int'($urandom_range(59)), int'($urandom_range(59)));
  endtask

  // outputs unchanged for four cycles means the pipeline has drained
  task automatic wait_stable();
    logic [47:0] last;
    int          same;
    int          cycles;
    last   = panel_out;
    same   = 0;
    cycles = 0;
    while (same < 4) begin
      @(negedge clk);
      cycles++;
      same = (panel_out === last) ? same + 1 : 0;
      last = panel_out;
      if (cycles > 40) begin
        $display("display outputs did not settle within 40 cycles");
        stop_with_failure();
      end
    end
  endtask

  task automatic wait_set_time();
    int cycles;
    cycles = 0;
    while (set_time !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > 20) begin
        $display("set_time never arrived after leaving the edit mode");
        stop_with_failure();
      end
    end
  endtask

  task automatic press_down();
    down_btn = 1'b0;
    repeat (2) @(negedge clk);
    down_btn = 1'b1;
  endtask

  task automatic press_up();
    up_btn = 1'b0;
    repeat (2) @(negedge clk);
    up_btn = 1'b1;
  endtask

  task automatic press_and_settle(input bit inc);
    if (inc) press_down();
    else press_up();
    wait_stable();
  endtask

  task automatic test_reset_values();
    check_frame('0);
    check_mask("dot", 8'hff, dot);
    check_mask("blink", 8'h00, blink);
    check_bit("set_time", 1'b0, set_time);
  endtask

  task automatic test_display();
    set_random_live();
    mode = clock_panel_pkg::TIME_DISP;
    wait_stable();
    check_time(lh, lmi, ls);
    check_mask("dot", 8'hff, dot);
    check_mask("blink", 8'h00, blink);
    mode = clock_panel_pkg::DATE_DISP;
    wait_stable();
    check_date(ly, lmo, ld);
    check_mask("dot", 8'b1110_1010, dot);
  endtask

  task automatic test_second_edit();
    int sec;
    set_random_live();
    set_live(ly, lmo, ld, lh, lmi, 57);  // close to the wrap
    mode = clock_panel_pkg::TIME_DISP;
    wait_stable();
    mode = clock_panel_pkg::TIME_EDIT_SECOND;
    wait_stable();
    check_mask("blink", 8'b0000_0011, blink);
    sec = ls;
    repeat (4) begin
      press_and_settle(1'b1);
      sec = next_value(sec, 0, 59, 1'b1);
      check_time(lh, lmi, sec);
    end
    repeat (2) begin
      press_and_settle(1'b0);
      sec = next_value(sec, 0, 59, 1'b0);
      check_time(lh, lmi, sec);
    end
    mode = clock_panel_pkg::TIME_DISP;
    wait_set_time();
    check_bcd2("new_second", to_bcd2(sec), new_second);
    check_bcd2("new_minute", to_bcd2(lmi), new_minute);
    check_bcd2("new_hour", to_bcd2(lh), new_hour);
    check_bcd2("new_day", to_bcd2(ld), new_day);
    check_bcd2("new_month", to_bcd2(lmo), new_month);
    check_bcd4("new_year", to_bcd4(ly), new_year);
    wait_stable();
  endtask

  task automatic test_wraps();
    set_live(2031, 12, 15, 23, 59, 30);
    mode = clock_panel_pkg::TIME_DISP;
    wait_stable();
    mode = clock_panel_pkg::TIME_EDIT_HOUR;
    wait_stable();
    check_mask("blink", 8'b1100_0000, blink);
    press_and_settle(1'b1);
    check_time(0, 59, 30);
    press_and_settle(1'b0);
    check_time(23, 59, 30);
    mode = clock_panel_pkg::TIME_EDIT_MINUTE;
    wait_stable();
    check_mask("blink", 8'b0001_1000, blink);
    press_and_settle(1'b1);
    check_time(23, 0, 30);
    mode = clock_panel_pkg::TIME_EDIT_MONTH;
    wait_stable();
    check_mask("blink", 8'b0000_1100, blink);
    check_date(2031, 12, 15);
    press_and_settle(1'b1);
    check_date(2031, 1, 15);
    press_and_settle(1'b0);
    check_date(2031, 12, 15);
    mode = clock_panel_pkg::TIME_DISP;
    wait_set_time();
    check_bcd2("new_minute", 8'h00, new_minute);
    check_bcd2("new_month", 8'h12, new_month);
    wait_stable();
  endtask

  task automatic test_day_and_year();
    set_live(2024, 2, 1, 12, 0, 0);
    mode = clock_panel_pkg::DATE_DISP;
    wait_stable();
    mode = clock_panel_pkg::TIME_EDIT_DAY;
    wait_stable();
    check_mask("blink", 8'b0000_0011, blink);
    check_mask("dot", 8'b1110_1010, dot);
    press_and_settle(1'b0);
    check_date(2024, 2, 29);  // leap year
    press_and_settle(1'b1);
    check_date(2024, 2, 1);
    mode = clock_panel_pkg::DATE_DISP;
    set_live(1900, 2, 1, 12, 0, 0);
    wait_stable();
    mode = clock_panel_pkg::TIME_EDIT_DAY;
    wait_stable();
    press_and_settle(1'b0);
    check_date(1900, 2, 28);
    mode = clock_panel_pkg::DATE_DISP;
    set_live(1970, 4, 10, 12, 0, 0);
    wait_stable();
    mode = clock_panel_pkg::TIME_EDIT_YEAR;
    wait_stable();
    check_mask("blink", 8'b1111_0000, blink);
    press_and_settle(1'b0);
    check_date(9999, 4, 10);
    mode = clock_panel_pkg::DATE_DISP;
    set_live(2023, 3, 31, 8, 45, 0);
    wait_stable();
    mode = clock_panel_pkg::TIME_EDIT_MONTH;
    wait_stable();
    press_and_settle(1'b1);
    check_date(2023, 4, 30);  // day pulled down to the april limit
    mode = clock_panel_pkg::TIME_DISP;
    wait_set_time();
    check_bcd2("new_day", 8'h30, new_day);
    check_bcd4("new_year", 16'h2023, new_year);
    wait_stable();
  endtask

  initial begin
    void'($urandom(32'h76c5_c168));
    clk      = 1'b0;
    rst_n    = 1'b0;
    mode     = clock_panel_pkg::TIME_DISP;
    up_btn   = 1'b1;
    down_btn = 1'b1;
    set_live(2000, 1, 1, 0, 0, 0);
    repeat (3) @(posedge clk);
    @(negedge clk);
    test_reset_values();
    rst_n = 1'b1;
    test_display();
    test_second_edit();
    test_wraps();
    test_day_and_year();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: sim.f
+incdir+hdl
hdl/clock_panel_pkg.sv
hdl/button_edge.sv
hdl/day_limit.sv
hdl/time_editor.sv
hdl/display_driver.sv
hdl/clock_panel.sv
testbench/clock_panel_props.sv
testbench/clock_panel_tb.sv

// File: run.sh
#!/bin/sh
# build and run the clock panel testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module clock_panel_tb -f sim.f -o clock_panel_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/clock_panel_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Simulation completed successfully$"; then
  exit 0
fi
exit 1
